/* tile_mem_fabric.f */
+incdir+include
rtl/tile_mem_pkg.sv
rtl/mem_cmd_decode.sv
rtl/cfg_regs.sv
rtl/clint_slice.sv
rtl/loopback_dev.sv
rtl/mem_resp_arb.sv
rtl/tile_mem_fabric.sv
bench/tb_clk_gen.sv
bench/tile_mem_props.sv
bench/tile_mem_checker.sv
bench/tile_mem_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tile memory fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tile_mem_fabric.f \
  --top-module tile_mem_fabric_tb \
  -o tile_mem_fabric_sim

out=$(./obj_dir/tile_mem_fabric_sim)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

/* bench/tile_mem_fabric_tb.sv */
// Tile memory fabric testbench
`timescale 1ns/1ps
`include "tile_mem_defs.svh"

module tile_mem_fabric_tb;

  localparam logic [63:0] EXT_KEY = 64'h5a5a_c3c3_0f0f_9696;
  localparam int          TIMEOUT = 400;
  localparam logic [31:0] CFG_BASE   = 32'h0020_0000;
  localparam logic [31:0] CLINT_BASE = 32'h0010_0000;

  logic                   clk_i;
  logic                   rst_n_i;
  tile_mem_pkg::mem_msg_t cmd_i;
  logic                   cmd_v_i;
  logic                   cmd_ready_o;
  tile_mem_pkg::mem_msg_t resp_o;
  logic                   resp_v_o;
  logic                   resp_ready_i;
  tile_mem_pkg::mem_msg_t ext_cmd_o;
  logic                   ext_cmd_v_o;
  logic                   ext_cmd_ready_i;
  tile_mem_pkg::mem_msg_t ext_resp_i;
  logic                   ext_resp_v_i;
  logic                   ext_resp_yumi_o;
  logic [3:0]             did_i;
  logic                   freeze_o;
  logic                   timer_irq_o;
  logic                   software_irq_o;

  logic                   exp_push;
  tile_mem_pkg::mem_msg_t exp_msg;
  logic [63:0]            exp_mask;
  logic                   exp_mono;
  int                     err_count;
  int                     pending;
  int                     checked;

  tile_mem_pkg::mem_msg_t ext_q [$];
  logic                   ext_busy;
  logic                   hold_resp;
  logic [3:0]             next_id;
  logic                   freeze_sh;
  logic                   msip_sh;
  logic [63:0]            scratch_sh;
  logic [63:0]            mtimecmp_sh;
  int                     tb_errs;
  int                     tests_run;
  int                     tests_failed;
  int                     errs_before;

  tb_clk_gen u_clk (.clk_o(clk_i), .rst_n_o(rst_n_i));

  tile_mem_fabric uut (.*);

  tile_mem_checker u_chk (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .resp_i(resp_o), .resp_v_i(resp_v_o), .resp_ready_i(resp_ready_i),
    .exp_push_i(exp_push), .exp_msg_i(exp_msg), .exp_mask_i(exp_mask),
    .exp_mono_i(exp_mono),
    .err_count_o(err_count), .pending_o(pending), .checked_o(checked)
  );

  bind tile_mem_fabric tile_mem_props u_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i),
    .ext_cmd_o(ext_cmd_o), .ext_cmd_v_o(ext_cmd_v_o),
    .grants_i({ext_resp_yumi_o, cfg_yumi, clint_yumi, loop_yumi})
  );

  // Expected response from the memory map rules
  function automatic tile_mem_pkg::mem_msg_t ref_resp(input tile_mem_pkg::mem_msg_t cmd,
                                                      output logic [63:0] mask,
                                                      output logic mono);
    logic [3:0]             dev;
    logic [4:0]             idx;
    logic [15:0]            ofs;
    tile_mem_pkg::mem_msg_t r;
    dev    = cmd.addr[`TILE_MEM_DEV_LSB +: 4];
    idx    = cmd.addr[7:3];
    ofs    = cmd.addr[15:0];
    r      = cmd;
    r.data = '0;
    mask   = '1;
    mono   = 1'b0;
    if (cmd.addr >= `TILE_MEM_DRAM_BASE || dev == `TILE_MEM_DEV_CACHE)
      r.data = {32'h0, cmd.addr} ^ EXT_KEY;
    else if (cmd.op == tile_mem_pkg::MEM_WR)
      r.data = '0;
    else if (dev == `TILE_MEM_DEV_CFG)
    begin
      if (idx == `CFG_REG_FREEZE)
        r.data = {63'b0, freeze_sh};
      else if (idx == `CFG_REG_DID)
        r.data = {60'b0, did_i};
      else if (idx == `CFG_REG_SCRATCH)
        r.data = scratch_sh;
    end
    else if (dev == `TILE_MEM_DEV_CLINT)
    begin
      if (ofs == `CLINT_MSIP_OFS)
        r.data = {63'b0, msip_sh};
      else if (ofs == `CLINT_MTIMECMP_OFS)
        r.data = mtimecmp_sh;
      else if (ofs == `CLINT_MTIME_OFS)
      begin
        mask = '0;
        mono = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("Timeout: %s at %0t", why, $time);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic sync_to_reset();
    int n;
    n = 0;
    while (!rst_n_i)
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        abort_run("reset never released");
    end
  endtask

  task automatic send(input logic wr, input logic [31:0] addr, input logic [63:0] data);
    tile_mem_pkg::mem_msg_t msg;
    tile_mem_pkg::mem_msg_t exp;
    logic [63:0]            mask;
    logic                   mono;
    int                     n;
    msg.op     = wr ? tile_mem_pkg::MEM_WR : tile_mem_pkg::MEM_RD;
    msg.src_id = next_id;
    msg.addr   = addr;
    msg.data   = data;
    next_id    = next_id + 1'b1;
    exp        = ref_resp(msg, mask, mono);
    // Shadow state follows the write
    if (wr && addr < `TILE_MEM_DRAM_BASE)
    begin
      if (addr[23:20] == `TILE_MEM_DEV_CFG && addr[7:3] == `CFG_REG_FREEZE)
        freeze_sh = data[0];
      if (addr[23:20] == `TILE_MEM_DEV_CFG && addr[7:3] == `CFG_REG_SCRATCH)
        scratch_sh = data;
      if (addr[23:20] == `TILE_MEM_DEV_CLINT && addr[15:0] == `CLINT_MSIP_OFS)
        msip_sh = data[0];
      if (addr[23:20] == `TILE_MEM_DEV_CLINT && addr[15:0] == `CLINT_MTIMECMP_OFS)
        mtimecmp_sh = data;
    end
    @(posedge clk_i);
    cmd_i    <= msg;
    cmd_v_i  <= 1'b1;
    exp_msg  <= exp;
    exp_mask <= mask;
    exp_mono <= mono;
    exp_push <= 1'b1;
    n = 0;
    do
    begin
      @(posedge clk_i);
      exp_push <= 1'b0;
      n++;
      if (n > TIMEOUT)
        abort_run("command not accepted");
    end
    while (!cmd_ready_o);
    cmd_v_i <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        abort_run("responses still outstanding");
    end
    while (pending != 0 || exp_push);
  endtask

  task automatic wait_irq(input logic timer, input logic level);
    int n;
    n = 0;
    while ((timer ? timer_irq_o : software_irq_o) !== level)
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        abort_run(timer ? "timer_irq_o did not change" : "software_irq_o did not change");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (exp !== got)
    begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
      tb_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    wait_idle();
    tests_run++;
    if (err_count + tb_errs != errs_before)
    begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_count + tb_errs - errs_before);
    end
    else
      $display("Test %s: passed", name);
    errs_before = err_count + tb_errs;
  endtask

  // External memory model
  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ext_q.delete();
      ext_cmd_ready_i <= 1'b0;
      ext_resp_v_i    <= 1'b0;
    end
    else
    begin
      if (ext_cmd_v_o && ext_cmd_ready_i)
      begin
        // Routed command leaves unchanged
        if (ext_cmd_o !== cmd_i)
        begin
          $display("Mismatch at %0t: ext_cmd_o expected %h got %h",
                   $time, cmd_i, ext_cmd_o);
          tb_errs++;
        end
        ext_q.push_back(ext_cmd_o);
      end
      ext_busy = ext_resp_v_i;
      if (ext_busy && ext_resp_yumi_o)
      begin
        void'(ext_q.pop_front());
        ext_busy = 1'b0;
      end
      if (!ext_busy && ext_q.size() > 0 && ($urandom % 2) == 0)
      begin
        ext_resp_i      <= '{op: ext_q[0].op, src_id: ext_q[0].src_id,
                             addr: ext_q[0].addr, data: {32'h0, ext_q[0].addr} ^ EXT_KEY};
        ext_resp_v_i    <= 1'b1;
      end
      else if (!ext_busy)
        ext_resp_v_i <= 1'b0;
      ext_cmd_ready_i <= ($urandom % 4) != 0;
    end
  end

  always @(posedge clk_i)
  begin
    if (rst_n_i)
      resp_ready_i <= hold_resp ? 1'b0 : (($urandom % 5) != 0);
  end

  initial
  begin
    void'($urandom(32'hf73f79f3));
    cmd_i       = '0;
    cmd_v_i     = 1'b0;
    resp_ready_i = 1'b0;
    ext_cmd_ready_i = 1'b0;
    ext_resp_i  = '0;
    ext_resp_v_i = 1'b0;
    did_i       = 4'h9;
    exp_push    = 1'b0;
    exp_msg     = '0;
    exp_mask    = '0;
    exp_mono    = 1'b0;
    hold_resp   = 1'b0;
    next_id     = '0;
    freeze_sh   = 1'b1;
    msip_sh     = 1'b0;
    scratch_sh  = '0;
    mtimecmp_sh = '1;
    tb_errs     = 0;
    tests_run   = 0;
    tests_failed = 0;
    errs_before = 0;
    sync_to_reset();

    check_bit("freeze_o", 1'b1, freeze_o);
    send(1'b0, CFG_BASE | 32'h00, '0);
    send(1'b1, CFG_BASE | 32'h00, 64'h0);
    send(1'b0, CFG_BASE | 32'h00, '0);
    wait_idle();
    check_bit("freeze_o", 1'b0, freeze_o);
    send(1'b1, CFG_BASE | 32'h10, {$urandom, $urandom});
    send(1'b0, CFG_BASE | 32'h10, '0);
    send(1'b0, CFG_BASE | 32'h08, '0);
    finish_test("config_regs");

    send(1'b1, CLINT_BASE | 32'h0000, 64'h1);
    wait_irq(1'b0, 1'b1);
    send(1'b0, CLINT_BASE | 32'h0000, '0);
    send(1'b1, CLINT_BASE | 32'h4000, 64'h40);
    wait_irq(1'b1, 1'b1);
    send(1'b1, CLINT_BASE | 32'h4000, '1);
    wait_irq(1'b1, 1'b0);
    send(1'b0, CLINT_BASE | 32'hBFF8, '0);
    send(1'b0, CLINT_BASE | 32'hBFF8, '0);
    finish_test("clint");

    send(1'b0, 32'h8000_0000, '0);
    send(1'b1, 32'hdead_bee8, {$urandom, $urandom});
    send(1'b0, 32'h0030_0040, '0);
    finish_test("external_routing");

    send(1'b0, 32'h0000_1000, '0);
    send(1'b1, 32'h0050_0010, {$urandom, $urandom});
    send(1'b0, 32'h7ff0_0008, '0);
    finish_test("loopback");

    hold_resp <= 1'b1;
    @(posedge clk_i);
    fork
      begin
        send(1'b0, 32'h9000_0100, '0);
        send(1'b0, CFG_BASE | 32'h10, '0);
        send(1'b0, CLINT_BASE | 32'h0000, '0);
        send(1'b0, 32'h0060_0000, '0);
        send(1'b1, 32'h0031_0008, {$urandom, $urandom});
        send(1'b0, 32'hf000_0000, '0);
      end
      begin
        // Queue fills and cmd_ready_o drops before the release
        repeat (40) @(posedge clk_i);
        hold_resp <= 1'b0;
      end
    join
    finish_test("back_pressure");

    $display("Tests: %0d run, %0d failed, %0d responses checked, %0d errors",
             tests_run, tests_failed, checked, err_count + tb_errs);
    if (tests_failed == 0 && err_count + tb_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* bench/tile_mem_checker.sv */
// Response scoreboard
`timescale 1ns/1ps
`include "tile_mem_defs.svh"

module tile_mem_checker
  (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  tile_mem_pkg::mem_msg_t      resp_i,
  input  logic                        resp_v_i,
  input  logic                        resp_ready_i,
  input  logic                        exp_push_i,
  input  tile_mem_pkg::mem_msg_t      exp_msg_i,
  input  logic [`TILE_MEM_DATA_W-1:0] exp_mask_i,
  input  logic                        exp_mono_i,
  output int                          err_count_o,
  output int                          pending_o,
  output int                          checked_o
  );

  tile_mem_pkg::mem_msg_t      exp_q    [16];
  logic [`TILE_MEM_DATA_W-1:0] mask_q   [16];
  logic                        mono_q   [16];
  logic                        busy_q   [16];
  logic [`TILE_MEM_DATA_W-1:0] last_mtime;
  int                          errs;
  int                          pend;
  int                          done;
  int                          id;

  initial
  begin
    for (int i = 0; i < 16; i++)
      busy_q[i] = 1'b0;
    last_mtime = '0;
    errs = 0;
    pend = 0;
    done = 0;
    err_count_o = 0;
    pending_o = 0;
    checked_o = 0;
  end

  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (exp_push_i)
      begin
        exp_q[exp_msg_i.src_id]  = exp_msg_i;
        mask_q[exp_msg_i.src_id] = exp_mask_i;
        mono_q[exp_msg_i.src_id] = exp_mono_i;
        busy_q[exp_msg_i.src_id] = 1'b1;
        pend++;
      end
      if (resp_v_i && resp_ready_i)
      begin
        id = resp_i.src_id;
        if (!busy_q[id])
        begin
          $display("Unexpected or duplicate response for src_id %0d at %0t", id, $time);
          errs++;
        end
        else
        begin
          if (resp_i.op != exp_q[id].op)
          begin
            $display("Mismatch at %0t: resp_o.op expected %0d got %0d",
                     $time, exp_q[id].op, resp_i.op);
            errs++;
          end
          if (resp_i.addr != exp_q[id].addr)
          begin
            $display("Mismatch at %0t: resp_o.addr expected %h got %h",
                     $time, exp_q[id].addr, resp_i.addr);
            errs++;
          end
          if ((resp_i.data & mask_q[id]) != (exp_q[id].data & mask_q[id]))
          begin
            $display("Mismatch at %0t: resp_o.data expected %h got %h",
                     $time, exp_q[id].data, resp_i.data);
            errs++;
          end
          // mtime never runs backwards
          if (mono_q[id])
          begin
            if (resp_i.data < last_mtime)
            begin
              $display("Mismatch at %0t: mtime expected >= %h got %h",
                       $time, last_mtime, resp_i.data);
              errs++;
            end
            last_mtime = resp_i.data;
          end
          busy_q[id] = 1'b0;
          pend--;
          done++;
        end
      end
    end
    err_count_o <= errs;
    pending_o   <= pend;
    checked_o   <= done;
  end

endmodule

/* bench/tile_mem_props.sv */
// Fabric handshake assertions
`timescale 1ns/1ps
`include "tile_mem_defs.svh"

module tile_mem_props
  (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input tile_mem_pkg::mem_msg_t resp_o,
  input logic                   resp_v_o,
  input logic                   resp_ready_i,
  input tile_mem_pkg::mem_msg_t ext_cmd_o,
  input logic                   ext_cmd_v_o,
  input logic [3:0]             grants_i
  );

  // Stalled response holds still
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o)))
    else $error("response changed while stalled");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_cmd_v_o |-> ((ext_cmd_o.addr >= `TILE_MEM_DRAM_BASE) ||
      (ext_cmd_o.addr[`TILE_MEM_DEV_LSB +: 4] == `TILE_MEM_DEV_CACHE)))
    else $error("external command with a local non-cache address");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(grants_i))
    else $error("more than one device granted");

endmodule

/* bench/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen
  (
  output logic clk_o,
  output logic rst_n_o
  );

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

/* rtl/tile_mem_fabric.sv */
// Tile memory-side device fabric
`timescale 1ns/1ps
`include "tile_mem_defs.svh"

module tile_mem_fabric
  (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  tile_mem_pkg::mem_msg_t    cmd_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  output tile_mem_pkg::mem_msg_t    resp_o,
  output logic                      resp_v_o,
  input  logic                      resp_ready_i,
  output tile_mem_pkg::mem_msg_t    ext_cmd_o,
  output logic                      ext_cmd_v_o,
  input  logic                      ext_cmd_ready_i,
  input  tile_mem_pkg::mem_msg_t    ext_resp_i,
  input  logic                      ext_resp_v_i,
  output logic                      ext_resp_yumi_o,
  input  logic [`TILE_MEM_ID_W-1:0] did_i,
  output logic                      freeze_o,
  output logic                      timer_irq_o,
  output logic                      software_irq_o
  );

  logic                   cfg_v, cfg_ready, cfg_resp_v, cfg_yumi;
  logic                   clint_v, clint_ready, clint_resp_v, clint_yumi;
  logic                   loop_v, loop_ready, loop_resp_v, loop_yumi;
  tile_mem_pkg::mem_msg_t cfg_resp, clint_resp, loop_resp;

  // Cache path goes straight out
  assign ext_cmd_o = cmd_i;

  mem_cmd_decode u_decode (
    .cmd_i(cmd_i), .cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o),
    .cache_v_o(ext_cmd_v_o), .cache_ready_i(ext_cmd_ready_i),
    .cfg_v_o(cfg_v), .cfg_ready_i(cfg_ready),
    .clint_v_o(clint_v), .clint_ready_i(clint_ready),
    .loop_v_o(loop_v), .loop_ready_i(loop_ready)
  );

  cfg_regs u_cfg (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_i(cmd_i), .cmd_v_i(cfg_v), .cmd_ready_o(cfg_ready),
    .resp_o(cfg_resp), .resp_v_o(cfg_resp_v), .resp_yumi_i(cfg_yumi),
    .did_i(did_i), .freeze_o(freeze_o)
  );

  clint_slice u_clint (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_i(cmd_i), .cmd_v_i(clint_v), .cmd_ready_o(clint_ready),
    .resp_o(clint_resp), .resp_v_o(clint_resp_v), .resp_yumi_i(clint_yumi),
    .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
  );

  loopback_dev u_loop (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_i(cmd_i), .cmd_v_i(loop_v), .cmd_ready_o(loop_ready),
    .resp_o(loop_resp), .resp_v_o(loop_resp_v), .resp_yumi_i(loop_yumi)
  );

  mem_resp_arb u_arb (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cache_resp_i(ext_resp_i), .cache_v_i(ext_resp_v_i), .cache_yumi_o(ext_resp_yumi_o),
    .cfg_resp_i(cfg_resp), .cfg_v_i(cfg_resp_v), .cfg_yumi_o(cfg_yumi),
    .clint_resp_i(clint_resp), .clint_v_i(clint_resp_v), .clint_yumi_o(clint_yumi),
    .loop_resp_i(loop_resp), .loop_v_i(loop_resp_v), .loop_yumi_o(loop_yumi),
    .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i)
  );

endmodule

/* rtl/mem_resp_arb.sv */
// Response arbiter and queue
`timescale 1ns/1ps

module mem_resp_arb
  (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  tile_mem_pkg::mem_msg_t cache_resp_i,
  input  logic                   cache_v_i,
  output logic                   cache_yumi_o,
  input  tile_mem_pkg::mem_msg_t cfg_resp_i,
  input  logic                   cfg_v_i,
  output logic                   cfg_yumi_o,
  input  tile_mem_pkg::mem_msg_t clint_resp_i,
  input  logic                   clint_v_i,
  output logic                   clint_yumi_o,
  input  tile_mem_pkg::mem_msg_t loop_resp_i,
  input  logic                   loop_v_i,
  output logic                   loop_yumi_o,
  output tile_mem_pkg::mem_msg_t resp_o,
  output logic                   resp_v_o,
  input  logic                   resp_ready_i
  );

  tile_mem_pkg::mem_msg_t sel_msg;
  tile_mem_pkg::mem_msg_t fifo_mem [2];
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [1:0]             count;
  logic                   room;
  logic                   push;
  logic                   pop;

  assign room = (count != 2'd2);

  // Fixed priority, cache highest
  assign cache_yumi_o = room & cache_v_i;
  assign cfg_yumi_o   = room & cfg_v_i & ~cache_v_i;
  assign clint_yumi_o = room & clint_v_i & ~cache_v_i & ~cfg_v_i;
  assign loop_yumi_o  = room & loop_v_i & ~cache_v_i & ~cfg_v_i & ~clint_v_i;

  always_comb
  begin
    if (cache_v_i)
      sel_msg = cache_resp_i;
    else if (cfg_v_i)
      sel_msg = cfg_resp_i;
    else if (clint_v_i)
      sel_msg = clint_resp_i;
    else
      sel_msg = loop_resp_i;
  end

  assign push = cache_yumi_o | cfg_yumi_o | clint_yumi_o | loop_yumi_o;
  assign pop  = resp_v_o & resp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      fifo_mem[wr_ptr] <= sel_msg;
  end

  assign resp_o   = fifo_mem[rd_ptr];
  assign resp_v_o = (count != 2'd0);

endmodule

/* rtl/loopback_dev.sv */
// Zero-data loopback responder
`timescale 1ns/1ps

module loopback_dev
  (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  tile_mem_pkg::mem_msg_t cmd_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_ready_o,
  output tile_mem_pkg::mem_msg_t resp_o,
  output logic                   resp_v_o,
  input  logic                   resp_yumi_i
  );

  logic                   accept;
  logic                   resp_v_r;
  tile_mem_pkg::mem_msg_t resp_r;

  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  // Header echoed, data always zero
  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{op: cmd_i.op, src_id: cmd_i.src_id, addr: cmd_i.addr, data: '0};
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

endmodule

/* rtl/clint_slice.sv */
// Core-local interruptor
`timescale 1ns/1ps
`include "tile_mem_defs.svh"

module clint_slice
  (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  tile_mem_pkg::mem_msg_t cmd_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_ready_o,
  output tile_mem_pkg::mem_msg_t resp_o,
  output logic                   resp_v_o,
  input  logic                   resp_yumi_i,
  output logic                   timer_irq_o,
  output logic                   software_irq_o
  );

  logic                        accept;
  logic                        is_wr;
  logic [15:0]                 ofs;
  logic                        sel_msip;
  logic                        sel_mtimecmp;
  logic                        sel_mtime;
  logic [`TILE_MEM_DATA_W-1:0] rd_data;
  logic                        msip_r;
  logic [`TILE_MEM_DATA_W-1:0] mtimecmp_r;
  logic [`TILE_MEM_DATA_W-1:0] mtime_r;
  logic                        resp_v_r;
  tile_mem_pkg::mem_msg_t      resp_r;

  assign cmd_ready_o  = ~resp_v_r;
  assign accept       = cmd_v_i & cmd_ready_o;
  assign is_wr        = (cmd_i.op == tile_mem_pkg::MEM_WR);
  assign ofs          = cmd_i.addr[15:0];
  assign sel_msip     = (ofs == `CLINT_MSIP_OFS);
  assign sel_mtimecmp = (ofs == `CLINT_MTIMECMP_OFS);
  assign sel_mtime    = (ofs == `CLINT_MTIME_OFS);

  always_comb
  begin
    rd_data = '0;
    if (sel_msip)
      rd_data[0] = msip_r;
    else if (sel_mtimecmp)
      rd_data = mtimecmp_r;
    else if (sel_mtime)
      rd_data = mtime_r;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      msip_r     <= 1'b0;
      mtimecmp_r <= '1;
      mtime_r    <= '0;
    end
    else
    begin
      if (accept && is_wr && sel_msip)
        msip_r <= cmd_i.data[0];
      if (accept && is_wr && sel_mtimecmp)
        mtimecmp_r <= cmd_i.data;
      // Free-running unless software loads it
      if (accept && is_wr && sel_mtime)
        mtime_r <= cmd_i.data;
      else
        mtime_r <= mtime_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{op: cmd_i.op, src_id: cmd_i.src_id, addr: cmd_i.addr,
                  data: (is_wr ? '0 : rd_data)};
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

/* rtl/cfg_regs.sv */
// Tile configuration registers
`timescale 1ns/1ps
`include "tile_mem_defs.svh"

module cfg_regs
  (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  tile_mem_pkg::mem_msg_t    cmd_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  output tile_mem_pkg::mem_msg_t    resp_o,
  output logic                      resp_v_o,
  input  logic                      resp_yumi_i,
  input  logic [`TILE_MEM_ID_W-1:0] did_i,
  output logic                      freeze_o
  );

  logic                        accept;
  logic                        is_wr;
  logic [4:0]                  reg_idx;
  logic [`TILE_MEM_DATA_W-1:0] rd_data;
  logic                        freeze_r;
  logic [`TILE_MEM_DATA_W-1:0] scratch_r;
  logic                        resp_v_r;
  tile_mem_pkg::mem_msg_t      resp_r;

  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign is_wr       = (cmd_i.op == tile_mem_pkg::MEM_WR);
  assign reg_idx     = cmd_i.addr[7:3];

  always_comb
  begin
    rd_data = '0;
    case (reg_idx)
      `CFG_REG_FREEZE:  rd_data[0] = freeze_r;
      `CFG_REG_DID:     rd_data[`TILE_MEM_ID_W-1:0] = did_i;
      `CFG_REG_SCRATCH: rd_data = scratch_r;
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r  <= 1'b1;
      scratch_r <= '0;
    end
    else if (accept && is_wr)
    begin
      if (reg_idx == `CFG_REG_FREEZE)
        freeze_r <= cmd_i.data[0];
      if (reg_idx == `CFG_REG_SCRATCH)
        scratch_r <= cmd_i.data;
    end
  end

  // One-entry response slot
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{op: cmd_i.op, src_id: cmd_i.src_id, addr: cmd_i.addr,
                  data: (is_wr ? '0 : rd_data)};
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;
  assign freeze_o = freeze_r;

endmodule

/* rtl/mem_cmd_decode.sv */
// Memory command decode
`timescale 1ns/1ps
`include "tile_mem_defs.svh"

module mem_cmd_decode
  (
  input  tile_mem_pkg::mem_msg_t cmd_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_ready_o,
  output logic                   cache_v_o,
  input  logic                   cache_ready_i,
  output logic                   cfg_v_o,
  input  logic                   cfg_ready_i,
  output logic                   clint_v_o,
  input  logic                   clint_ready_i,
  output logic                   loop_v_o,
  input  logic                   loop_ready_i
  );

  logic       is_local;
  logic [3:0] dev;
  logic       is_cache;
  logic       is_cfg;
  logic       is_clint;
  logic       is_loop;

  assign is_local = (cmd_i.addr < `TILE_MEM_DRAM_BASE);
  assign dev      = cmd_i.addr[`TILE_MEM_DEV_LSB +: 4];

  // Cache wins first, then cfg, then CLINT
  assign is_cache = ~is_local | (dev == `TILE_MEM_DEV_CACHE);
  assign is_cfg   = ~is_cache & (dev == `TILE_MEM_DEV_CFG);
  assign is_clint = ~is_cache & (dev == `TILE_MEM_DEV_CLINT);
  assign is_loop  = ~is_cache & ~is_cfg & ~is_clint;

  assign cmd_ready_o = cache_ready_i & cfg_ready_i & clint_ready_i & loop_ready_i;

  // Each valid waits on the other targets so a target never takes a
  // command that the source still holds
  assign cache_v_o = cmd_v_i & is_cache & cfg_ready_i & clint_ready_i & loop_ready_i;
  assign cfg_v_o   = cmd_v_i & is_cfg & cache_ready_i & clint_ready_i & loop_ready_i;
  assign clint_v_o = cmd_v_i & is_clint & cache_ready_i & cfg_ready_i & loop_ready_i;
  assign loop_v_o  = cmd_v_i & is_loop & cache_ready_i & cfg_ready_i & clint_ready_i;

endmodule

/* rtl/tile_mem_pkg.sv */
// Tile memory fabric types
`include "tile_mem_defs.svh"

package tile_mem_pkg;

  // Memory command opcode
  typedef enum logic [0:0] {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  // Shared by commands and responses
  typedef struct packed {
    mem_op_e                     op;
    logic [`TILE_MEM_ID_W-1:0]   src_id;
    logic [`TILE_MEM_ADDR_W-1:0] addr;
    logic [`TILE_MEM_DATA_W-1:0] data;
  } mem_msg_t;

endpackage

/* include/tile_mem_defs.svh */
// Tile memory fabric definitions
`ifndef TILE_MEM_DEFS_SVH
`define TILE_MEM_DEFS_SVH

// Message field widths
`define TILE_MEM_ADDR_W 32
`define TILE_MEM_DATA_W 64
`define TILE_MEM_ID_W   4

// Local memory map
`define TILE_MEM_DRAM_BASE 32'h8000_0000
`define TILE_MEM_DEV_LSB   20

// Device codes in addr[DEV_LSB +: 4]
`define TILE_MEM_DEV_CLINT 4'd1
`define TILE_MEM_DEV_CFG   4'd2
`define TILE_MEM_DEV_CACHE 4'd3

// Config register indices, addr[7:3]
`define CFG_REG_FREEZE  5'd0
`define CFG_REG_DID     5'd1
`define CFG_REG_SCRATCH 5'd2

// CLINT offsets, addr[15:0]
`define CLINT_MSIP_OFS     16'h0000
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MTIME_OFS    16'hBFF8

`endif
